// ==== sim.f ====
+incdir+include
logic/pcie_tlp_pkg.sv
logic/rd_track_pkg.sv
logic/rd_alloc.sv
logic/rd_cpl_track.sv
logic/rd_credit_return.sv
logic/rd_outbound.sv
bench/tb_rd_outbound.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_rd_outbound -o tb_rd_outbound

# the simulator exit code is not trusted, the log decides
./obj_dir/tb_rd_outbound 2>&1 | tee sim.log || true

grep -qx "test passed" sim.log
echo "simulation log is in sim.log"

// ==== bench/tb_rd_outbound.sv ====
`include "rd_config.svh"

module tb_rd_outbound;
    import pcie_tlp_pkg::*;

    localparam int PHASE_REQS   = 50;
    localparam int DMA_OFF_REQS = 4;
    localparam int TOTAL_REQS   = 2 * PHASE_REQS + DMA_OFF_REQS + 1;
    localparam int INIT_CYCLES  = 2 ** (`RD_TAG_W + 1);
    localparam int TIMEOUT      = TOTAL_REQS * 400 + INIT_CYCLES + 8;
    // largest read that fits 8 header and 64 data credits at a 128 byte rcb
    localparam int MAX_LEN      = 256;

    logic    clk;
    logic    rst;
    logic    req_valid;
    rd_req_t req;
    logic    req_ready;
    logic    tlp_valid;
    rd_tlp_t tlp;
    logic    tlp_ready;
    logic    cpl_valid;
    cpl_t    cpl;
    logic    tlp_pending;
    logic    dma_en;
    logic    rcb;

    // accepted requests waiting for their header
    logic [`RD_ADDR_W-1:2] acc_addr [$];
    int                    acc_len [$];
    int                    acc_rcb [$];
    // issued reads still owed completions
    int out_tag [$];
    int out_addr [$];
    int out_rem [$];
    int out_rcb [$];
    int out_seq [$];

    // optimistic budget, frees counted at the completion strobe
    int          m_cplh;
    int          m_cpld;
    int          m_buf;
    int          issued;
    int          req_left;
    logic        max_mode;
    int          cycles;
    // cycles since the most recent completion strobe
    int          since_cpl;
    int unsigned seed_val;

    rd_outbound dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .tlp_valid   (tlp_valid),
        .tlp         (tlp),
        .tlp_ready   (tlp_ready),
        .cpl_valid   (cpl_valid),
        .cpl         (cpl),
        .tlp_pending (tlp_pending),
        .dma_en      (dma_en),
        .rcb         (rcb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic int ceil_div(input int num, input int den);
        return (num + den - 1) / den;
    endfunction

    task automatic new_request();
        logic [`RD_ADDR_W-1:2] addr;
        int                    len;
        addr = (`RD_ADDR_W - 2)'({$urandom, $urandom});
        if (max_mode) begin
            len       = MAX_LEN;
            addr[6:2] = '0;
        end else if ($urandom % 4 == 0) begin
            len = 1;
        end else begin
            // rcb offset plus length stays within 8 header credits
            len = rcb ? 1 + $urandom % 224 : 1 + $urandom % 112;
        end
        req_valid <= 1'b1;
        req.addr  <= addr;
        req.len   <= 10'(len);
        req_left  = req_left - 1;
    endtask

    task automatic take_tlp();
        logic [`RD_ADDR_W-1:2] addr;
        int                    len;
        int                    rdw;
        int                    lo;
        int                    need_h;
        int                    need_d;
        if (acc_len.size() == 0) begin
            stop_run("read header issued with no accepted request behind it");
        end
        addr = acc_addr.pop_front();
        len  = acc_len.pop_front();
        rdw  = acc_rcb.pop_front();
        check_value("tlp.addr", tlp.addr, addr);
        check_value("tlp.len", tlp.len, 10'(len));
        check_value("tlp.be_first", tlp.be_first, 4'hF);
        check_value("tlp.be_last", tlp.be_last, (len == 1) ? 4'h0 : 4'hF);
        foreach (out_tag[i]) begin
            if (out_tag[i] == int'(tlp.tag)) begin
                stop_run($sformatf("tag %0d issued while its read is outstanding", tlp.tag));
            end
        end
        lo     = int'(addr[12:2]);
        need_h = ceil_div(lo % rdw + len, rdw);
        need_d = ceil_div(lo % 4 + len, 4);
        if (need_h > m_cplh) begin
            stop_run("read header issued without enough completion header credits");
        end
        if (need_d > m_cpld) begin
            stop_run("read header issued without enough completion data credits");
        end
        if (len > m_buf) begin
            stop_run("read header issued without enough receive buffer space");
        end
        m_cplh -= need_h;
        m_cpld -= need_d;
        m_buf  -= len;
        out_tag.push_back(int'(tlp.tag));
        out_addr.push_back(lo);
        out_rem.push_back(len);
        out_rcb.push_back(rdw);
        out_seq.push_back(issued);
        issued++;
        if (out_tag.size() >= 2 ** `RD_TAG_W) begin
            stop_run("too many reads outstanding at once");
        end
    endtask

    task automatic send_cpl();
        int idx;
        int n;
        // a stale oldest read goes first so its tag is free before reuse
        if (issued - out_seq[0] >= 16) begin
            idx = 0;
        end else begin
            idx = $urandom % out_tag.size();
        end
        n = out_rcb[idx] - out_addr[idx] % out_rcb[idx];
        if (n > out_rem[idx]) begin
            n = out_rem[idx];
        end
        cpl_valid <= 1'b1;
        cpl.tag   <= `RD_TAG_W'(out_tag[idx]);
        cpl.len   <= 10'(n);
        since_cpl = 0;
        m_cplh += 1;
        m_cpld += ceil_div(out_addr[idx] % 4 + n, 4);
        m_buf  += n;
        out_addr[idx] += n;
        out_rem[idx]  -= n;
        if (out_rem[idx] == 0) begin
            out_tag.delete(idx);
            out_addr.delete(idx);
            out_rem.delete(idx);
            out_rcb.delete(idx);
            out_seq.delete(idx);
        end
    endtask

    // monitor and driver share one process, values sampled before the edge
    always @(posedge clk) begin
        if (!rst) begin
            if (!dma_en) begin
                check_value("req_ready", req_ready, 0);
            end
            if (out_tag.size() != 0) begin
                check_value("tlp_pending", tlp_pending, 1);
            end else if (!tlp_valid && since_cpl > 8) begin
                // last tag has had time to come back
                check_value("tlp_pending", tlp_pending, 0);
            end
            since_cpl = since_cpl + 1;
            if (req_valid && req_ready) begin
                acc_addr.push_back(req.addr);
                acc_len.push_back((req.len == 10'd0) ? 1024 : int'(req.len));
                acc_rcb.push_back(rcb ? 32 : 16);
            end
            if (tlp_valid && tlp_ready) begin
                take_tlp();
            end
            tlp_ready <= ($urandom % 4 != 0);
            cpl_valid <= 1'b0;
            if (out_tag.size() != 0 && $urandom % 4 != 0) begin
                send_cpl();
            end
            if (req_valid && !req_ready) begin
                req_valid <= 1'b1;
            end else if (req_left > 0 && $urandom % 2 == 0) begin
                new_request();
            end else begin
                req_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            stop_run($sformatf("timeout, run still busy after %0d cycles", cycles));
        end
    end

    task automatic wait_drain();
        @(negedge clk);
        while (req_left != 0 || req_valid || acc_len.size() != 0 || tlp_valid ||
               out_tag.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_phase(input logic use_rcb, input int count);
        @(posedge clk);
        rcb    <= use_rcb;
        dma_en <= 1'b1;
        @(negedge clk);
        req_left = count;
        wait_drain();
    endtask

    initial begin
        seed_val  = $urandom(32'h328f03f5);
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        tlp_ready = 1'b0;
        cpl_valid = 1'b0;
        cpl       = '0;
        dma_en    = 1'b0;
        rcb       = 1'b0;
        m_cplh    = `RD_CPLH;
        m_cpld    = `RD_CPLD;
        m_buf     = 2 ** `RD_BUFA_W;
        issued    = 0;
        req_left  = 0;
        max_mode  = 1'b0;
        cycles    = 0;
        since_cpl = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // 64 byte rcb, then 128 byte rcb
        run_phase(1'b0, PHASE_REQS);
        run_phase(1'b1, PHASE_REQS);

        // requests must wait while dma is off
        @(posedge clk);
        dma_en <= 1'b0;
        @(negedge clk);
        req_left = DMA_OFF_REQS;
        repeat (30) @(posedge clk);
        dma_en <= 1'b1;
        wait_drain();

        // full size read needs every credit back
        max_mode = 1'b1;
        req_left = 1;
        wait_drain();
        repeat (40) @(negedge clk);
        check_value("tlp_pending", tlp_pending, 0);
        check_value("issued", issued, TOTAL_REQS);
        $display("test passed");
        $finish;
    end

endmodule

// ==== logic/rd_outbound.sv ====
module rd_outbound (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  pcie_tlp_pkg::rd_req_t   req,
    output logic                    req_ready,
    output logic                    tlp_valid,
    output pcie_tlp_pkg::rd_tlp_t   tlp,
    input  logic                    tlp_ready,
    input  logic                    cpl_valid,
    input  pcie_tlp_pkg::cpl_t      cpl,
    output logic                    tlp_pending,
    input  logic                    dma_en,
    input  logic                    rcb
);
    import rd_track_pkg::*;

    logic        alloc_valid;
    alloc_t      alloc;
    logic        free_valid;
    free_cnt_t   free_cnt;
    free_pulse_t free_pulse;

    rd_alloc u_alloc (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .tlp_valid   (tlp_valid),
        .tlp         (tlp),
        .tlp_ready   (tlp_ready),
        .alloc_valid (alloc_valid),
        .alloc       (alloc),
        .free        (free_pulse),
        .tlp_pending (tlp_pending),
        .dma_en      (dma_en),
        .rcb         (rcb)
    );

    rd_cpl_track u_cpl_track (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc       (alloc),
        .cpl_valid   (cpl_valid),
        .cpl         (cpl),
        .free_valid  (free_valid),
        .free        (free_cnt)
    );

    rd_credit_return u_credit_return (
        .clk         (clk),
        .rst         (rst),
        .free_valid  (free_valid),
        .free        (free_cnt),
        .pulse       (free_pulse)
    );

endmodule

// ==== logic/rd_credit_return.sv ====
`include "rd_config.svh"

module rd_credit_return (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      free_valid,
    input  rd_track_pkg::free_cnt_t   free,
    output rd_track_pkg::free_pulse_t pulse
);
    // common counter width, data credits or dwords are the widest amounts
    localparam int CW = (`RD_FCDB > `RD_BUFA_W + 1) ? `RD_FCDB : `RD_BUFA_W + 1;

    logic [CW-1:0] amt [4];
    logic [3:0]    pv;

    // index order follows the pulse struct, cplh on top
    assign amt[3] = CW'(free.cplh);
    assign amt[2] = CW'(free.cpld);
    assign amt[1] = CW'(free.tag_done);
    assign amt[0] = CW'(free.dw);

    for (genvar i = 0; i < 4; i++) begin : g_cnt
        logic [CW-1:0] pend;
        logic [CW:0]   sum;

        assign pv[i] = (pend != '0);
        assign sum   = {1'b0, pend} + (free_valid ? {1'b0, amt[i]} : '0);

        // one release per cycle while anything is queued
        always_ff @(posedge clk) begin
            if (rst) begin
                pend <= '0;
            end else begin
                pend <= sum[CW-1:0] - CW'(pv[i]);
            end
        end

        a_no_overflow: assert property (@(posedge clk) disable iff (rst)
            !sum[CW]);
    end

    assign pulse = rd_track_pkg::free_pulse_t'(pv);

endmodule

// ==== logic/rd_cpl_track.sv ====
`include "rd_config.svh"

module rd_cpl_track (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc_valid,
    input  rd_track_pkg::alloc_t    alloc,
    input  logic                    cpl_valid,
    input  pcie_tlp_pkg::cpl_t      cpl,
    output logic                    free_valid,
    output rd_track_pkg::free_cnt_t free
);
    localparam int TAG_W  = `RD_TAG_W;
    localparam int BUFA_W = `RD_BUFA_W;
    localparam int FCHB   = `RD_FCHB;
    localparam int FCDB   = `RD_FCDB;

    typedef struct packed {
        logic [10:0]     rem;
        logic [6:2]      addr;
    } entry_t;

    entry_t           entry_mem [2 ** (TAG_W + 1)];
    // generation of the read currently owning each pcie tag
    logic             gen_mem [2 ** TAG_W];

    entry_t           a_entry;
    entry_t           c_entry;
    logic             hit;
    logic             c_gen;
    logic [TAG_W:0]   c_idx;
    logic [10:0]      c_len;
    logic [11:0]      cpld_sum;

    assign a_entry.rem  = alloc.init ? 11'd0 :
                          (alloc.len == 10'd0) ? 11'd1024 : {1'b0, alloc.len};
    assign a_entry.addr = alloc.addr;

    // completion may land in the same cycle as its table write
    assign hit     = alloc_valid && (alloc.tag[TAG_W-1:0] == cpl.tag);
    assign c_gen   = hit ? alloc.tag[TAG_W] : gen_mem[cpl.tag];
    assign c_idx   = {c_gen, cpl.tag};
    assign c_entry = hit ? a_entry : entry_mem[c_idx];

    assign c_len    = {1'b0, cpl.len};
    assign cpld_sum = 12'(c_entry.addr[3:2]) + 12'(c_len) + 12'd3;

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            entry_mem[alloc.tag]            <= a_entry;
            gen_mem[alloc.tag[TAG_W-1:0]]   <= alloc.tag[TAG_W];
        end
        // advance overrides a same-cycle alloc of this entry
        if (cpl_valid) begin
            entry_mem[c_idx].rem  <= c_entry.rem - c_len;
            entry_mem[c_idx].addr <= c_entry.addr + c_len[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free_valid <= 1'b0;
        end else begin
            free_valid <= cpl_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cpl_valid) begin
            free.cplh     <= FCHB'(1);
            free.cpld     <= FCDB'(cpld_sum[11:2]);
            free.dw       <= (BUFA_W + 1)'(c_len);
            free.tag_done <= (c_entry.rem == c_len);
        end
    end

    a_cpl_len: assert property (@(posedge clk) disable iff (rst)
        cpl_valid |-> c_len <= c_entry.rem);

endmodule

// ==== logic/rd_alloc.sv ====
`include "rd_config.svh"

module rd_alloc (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  pcie_tlp_pkg::rd_req_t     req,
    output logic                      req_ready,
    output logic                      tlp_valid,
    output pcie_tlp_pkg::rd_tlp_t     tlp,
    input  logic                      tlp_ready,
    output logic                      alloc_valid,
    output rd_track_pkg::alloc_t      alloc,
    input  rd_track_pkg::free_pulse_t free,
    output logic                      tlp_pending,
    input  logic                      dma_en,
    input  logic                      rcb
);
    import rd_track_pkg::*;

    localparam int ADDR_W = `RD_ADDR_W;
    localparam int TAG_W  = `RD_TAG_W;
    localparam int BUFA_W = `RD_BUFA_W;
    localparam int FCHB   = `RD_FCHB;
    localparam int FCDB   = `RD_FCDB;
    // wide enough that the sign bit of the buffer check is meaningful
    localparam int BSW    = (BUFA_W + 2 > 12) ? BUFA_W + 2 : 12;

    localparam logic [FCHB-1:0]   CPLH_INIT = FCHB'(`RD_CPLH);
    localparam logic [FCDB-1:0]   CPLD_INIT = FCDB'(`RD_CPLD);
    localparam logic [BUFA_W:0]   BUF_INIT  = (BUFA_W + 1)'(2 ** BUFA_W);

    logic              h_valid;
    logic              h_ready;
    logic              h_xfer;
    logic [ADDR_W-1:2] h_addr;
    logic [10:0]       h_len;
    logic [6:0]        h_cplh;
    logic [8:0]        h_cpld;

    logic [10:0]       req_len;
    logic [11:0]       cplh_pre;
    logic [11:0]       cpld_pre;

    logic [FCHB-1:0]   cplh_avail;
    logic [FCDB-1:0]   cpld_avail;
    logic [FCHB:0]     cplh_sub;
    logic [FCDB:0]     cpld_sub;

    logic [TAG_W:0]    tag;
    logic [TAG_W-1:0]  tag_cnt;
    logic              tag_init;
    logic              tag_max;

    logic [BUFA_W:0]   buf_avail;
    logic [BUFA_W:0]   buf_addr;
    logic [BSW-1:0]    buf_sub;

    alloc_t            a_next;
    alloc_t            a_q;
    logic              a_valid_q;

    assign req_len = (req.len == 10'd0) ? 11'd1024 : {1'b0, req.len};

    // rcb offset plus length, rounded up to whole rcbs or 16 byte units
    assign cplh_pre = rcb ? 12'(req.addr[6:2]) + 12'(req_len) + 12'd31
                          : 12'(req.addr[5:2]) + 12'(req_len) + 12'd15;
    assign cpld_pre = 12'(req.addr[3:2]) + 12'(req_len) + 12'd3;

    assign req_ready = !h_valid && dma_en;
    assign h_xfer    = h_valid && h_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            h_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            h_valid <= 1'b1;
        end else if (h_ready) begin
            h_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            h_addr <= req.addr;
            h_len  <= req_len;
            h_cplh <= rcb ? 7'(cplh_pre[11:5]) : 7'(cplh_pre[11:4]);
            h_cpld <= 9'(cpld_pre[11:2]);
        end
    end

    // completion credits, a borrow means not enough space
    assign cplh_sub = {1'b0, cplh_avail} - (FCHB + 1)'(h_cplh);
    assign cpld_sub = {1'b0, cpld_avail} - (FCDB + 1)'(h_cpld);
    assign buf_sub  = BSW'(buf_avail) - BSW'(h_len);

    always_ff @(posedge clk) begin
        if (rst) begin
            cplh_avail <= CPLH_INIT;
            cpld_avail <= CPLD_INIT;
            buf_avail  <= BUF_INIT;
            buf_addr   <= '0;
        end else begin
            cplh_avail <= (h_xfer ? cplh_sub[FCHB-1:0] : cplh_avail) + FCHB'(free.cplh);
            cpld_avail <= (h_xfer ? cpld_sub[FCDB-1:0] : cpld_avail) + FCDB'(free.cpld);
            buf_avail  <= (h_xfer ? buf_sub[BUFA_W:0] : buf_avail) + (BUFA_W + 1)'(free.data);
            if (h_xfer) begin
                buf_addr <= buf_addr + (BUFA_W + 1)'(h_len);
            end
        end
    end

    // tag counter walks every table entry once after reset
    assign tag_max = &tag_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            tag      <= '0;
            tag_cnt  <= '0;
            tag_init <= 1'b1;
        end else begin
            if (tag_init && (&tag)) begin
                tag_init <= 1'b0;
            end
            if (tag_init || h_xfer) begin
                tag <= tag + 1'b1;
            end
            if (h_xfer && !free.tag) begin
                tag_cnt <= tag_cnt + 1'b1;
            end else if (!h_xfer && free.tag) begin
                tag_cnt <= tag_cnt - 1'b1;
            end
        end
    end

    assign h_ready = !tag_init && !tag_max && !tlp_valid &&
                     !cplh_sub[FCHB] && !cpld_sub[FCDB] && !buf_sub[BSW-1];

    assign a_next.init = tag_init;
    assign a_next.tag  = tag;
    assign a_next.len  = h_len[9:0];
    assign a_next.addr = h_addr[6:2];
    assign a_next.bufa = buf_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_valid_q   <= 1'b0;
            alloc_valid <= 1'b0;
            tlp_valid   <= 1'b0;
            tlp_pending <= 1'b0;
        end else begin
            // table write trails the header by one cycle
            a_valid_q   <= tag_init || h_xfer;
            alloc_valid <= a_valid_q;
            tlp_pending <= (tag_cnt != '0);
            if (tlp_ready) begin
                tlp_valid <= 1'b0;
            end
            if (h_xfer) begin
                tlp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        a_q   <= a_next;
        alloc <= a_q;
        if (h_xfer) begin
            tlp.addr     <= h_addr;
            tlp.len      <= h_len[9:0];
            tlp.tag      <= tag[TAG_W-1:0];
            tlp.be_first <= 4'hF;
            tlp.be_last  <= (h_len == 11'd1) ? 4'h0 : 4'hF;
        end
    end

    // returned credits never exceed what was advertised
    a_avail_bound: assert property (@(posedge clk) disable iff (rst)
        cplh_avail <= CPLH_INIT && cpld_avail <= CPLD_INIT && buf_avail <= BUF_INIT);

    a_tlp_hold: assert property (@(posedge clk) disable iff (rst)
        tlp_valid && !tlp_ready |=> tlp_valid);

endmodule

// ==== logic/rd_track_pkg.sv ====
`include "rd_config.svh"

package rd_track_pkg;

    // tag table write from the allocator
    typedef struct packed {
        logic                  init;
        // msb is the generation bit
        logic [`RD_TAG_W:0]    tag;
        logic [9:0]            len;
        logic [6:2]            addr;
        logic [`RD_BUFA_W:0]   bufa;
    } alloc_t;

    // single cycle release strobes back to the allocator
    typedef struct packed {
        logic cplh;
        logic cpld;
        logic tag;
        logic data;
    } free_pulse_t;

    // amounts released by one completion
    typedef struct packed {
        logic [`RD_FCHB-1:0]   cplh;
        logic [`RD_FCDB-1:0]   cpld;
        logic [`RD_BUFA_W:0]   dw;
        logic                  tag_done;
    } free_cnt_t;

endpackage

// ==== logic/pcie_tlp_pkg.sv ====
`include "rd_config.svh"

package pcie_tlp_pkg;

    // read request from the local requester
    typedef struct packed {
        logic [`RD_ADDR_W-1:2] addr;
        // dword count where zero means 1024
        logic [9:0]            len;
    } rd_req_t;

    // memory read header towards the arbiter
    typedef struct packed {
        logic [`RD_ADDR_W-1:2] addr;
        logic [9:0]            len;
        logic [`RD_TAG_W-1:0]  tag;
        logic [3:0]            be_first;
        logic [3:0]            be_last;
    } rd_tlp_t;

    // completion strobe, one per rcb-split completion
    typedef struct packed {
        logic [`RD_TAG_W-1:0]  tag;
        // dwords carried by this completion
        logic [9:0]            len;
    } cpl_t;

endpackage

// ==== include/rd_config.svh ====
`ifndef RD_CONFIG_SVH
`define RD_CONFIG_SVH

// upper bound of the dword address, bits RD_ADDR_W-1 down to 2 are carried
`define RD_ADDR_W 64

// pcie tag width, the allocator adds one generation bit on top
`define RD_TAG_W 5

// receive buffer holds 2**RD_BUFA_W dwords
`define RD_BUFA_W 9

// advertised completion space
`define RD_CPLH 8
`define RD_CPLD 64

// credit counter widths
`define RD_FCHB 8
`define RD_FCDB 12

`endif
